/* Makefile */
VERILATOR  ?= verilator
TOP        ?= rx_vote_tb
FILELIST   ?= list.f
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   := ** PASS **

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hw/frame_dispatcher.sv */
`timescale 1ns/1ps

module frame_dispatcher #(
	parameter int SEGMENT_NUM_MAX = 4,
	parameter int SEG_OFFSET = 2
) (
	input  logic               rx_clk,
	input  logic               rst,
	input  rx_vote_pkg::byte_t rx_data,
	input  logic               rx_enable,
	output logic               bad_segment,
	payload_if.src             pl
);
	import rx_vote_pkg::*;

	localparam int CNT_W = $clog2(SEG_OFFSET + 3);
	localparam logic [CNT_W-1:0] HI_POS = CNT_W'(SEG_OFFSET);
	localparam logic [CNT_W-1:0] LO_POS = CNT_W'(SEG_OFFSET + 1);
	localparam seg_t SEG_LIMIT = seg_t'(SEGMENT_NUM_MAX);

	disp_state_e      state;
	logic [CNT_W-1:0] cnt;
	byte_t            seg_hi;
	logic             in_header;
	logic             seg_ok;

	assign in_header = (state == IDLE) || (state == HEADER);
	assign seg_ok = pl.segment < SEG_LIMIT;

	// Byte position inside the header, frozen once the payload starts.
	always_ff @(posedge rx_clk) begin
		if (rst) begin
			cnt <= '0;
		end else if (!rx_enable) begin
			cnt <= '0;
		end else if (in_header) begin
			cnt <= cnt + 1'b1;
		end
	end

	always_ff @(posedge rx_clk) begin
		if (rx_enable && in_header && (cnt == HI_POS)) begin
			seg_hi <= rx_data;
		end
	end

	// Input register, doubles as the payload byte.
	always_ff @(posedge rx_clk) begin
		pl.data <= rx_data;
	end

	always_ff @(posedge rx_clk) begin
		if (rst) begin
			state       <= IDLE;
			pl.segment  <= '0;
			pl.valid    <= 1'b0;
			pl.frame_end <= 1'b0;
			bad_segment <= 1'b0;
		end else begin
			pl.valid     <= 1'b0;
			pl.frame_end <= 1'b0;
			bad_segment  <= 1'b0;
			case (state)
				IDLE, HEADER: begin
					if (!rx_enable) begin
						state <= IDLE;
					end else if (cnt == LO_POS) begin
						pl.segment <= {seg_hi, rx_data};
						state      <= PAYLOAD;
					end else begin
						state <= HEADER;
					end
				end
				PAYLOAD: begin
					// Range is checked on the first cycle the full number is known.
					if (!seg_ok) begin
						bad_segment <= 1'b1;
						state       <= rx_enable ? DROP : IDLE;
					end else if (rx_enable) begin
						pl.valid <= 1'b1;
					end else begin
						pl.frame_end <= 1'b1;
						state        <= IDLE;
					end
				end
				DROP: begin
					if (!rx_enable) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

/* hw/payload_if.sv */
`timescale 1ns/1ps

interface payload_if;
	import rx_vote_pkg::*;

	byte_t data;
	logic  valid;
	seg_t  segment;
	logic  frame_end;

	// Dispatcher side.
	modport src (
		output data,
		output valid,
		output segment,
		output frame_end
	);

	// Voter side.
	modport dst (
		input data,
		input valid,
		input segment,
		input frame_end
	);

endinterface

/* hw/rx_vote_pkg.sv */
package rx_vote_pkg;

	// One byte of the receive stream.
	typedef logic [7:0] byte_t;

	// Segment number carried big-endian in the frame header.
	typedef logic [15:0] seg_t;

	// Dispatcher FSM.
	typedef enum logic [1:0] {
		IDLE,
		HEADER,
		PAYLOAD,
		DROP
	} disp_state_e;

	// Which copy of a segment the voter expects next.
	typedef enum logic [1:0] {
		COPY_A,
		COPY_B,
		COPY_VOTE
	} copy_e;

endpackage

/* hw/rx_vote_top.sv */
`timescale 1ns/1ps

module rx_vote_top #(
	parameter int SEGMENT_NUM_MAX = 4,
	parameter int SEG_OFFSET = 2,
	parameter int MAX_PAYLOAD = 16
) (
	input  logic               rx_clk,
	input  logic               rst,
	input  rx_vote_pkg::byte_t rx_data,
	input  logic               rx_enable,
	output logic               en_out,
	output rx_vote_pkg::byte_t data_out,
	output logic               loss_detected,
	output logic               bad_segment
);

	// Routed payload from dispatcher to voters.
	payload_if pl ();

	frame_dispatcher #(
		.SEGMENT_NUM_MAX (SEGMENT_NUM_MAX),
		.SEG_OFFSET      (SEG_OFFSET)
	) u_dispatcher (
		.rx_clk      (rx_clk),
		.rst         (rst),
		.rx_data     (rx_data),
		.rx_enable   (rx_enable),
		.bad_segment (bad_segment),
		.pl          (pl.src)
	);

	voter_bank #(
		.SEGMENT_NUM_MAX (SEGMENT_NUM_MAX),
		.MAX_PAYLOAD     (MAX_PAYLOAD)
	) u_bank (
		.rx_clk        (rx_clk),
		.rst           (rst),
		.pl            (pl.dst),
		.en_out        (en_out),
		.data_out      (data_out),
		.loss_detected (loss_detected)
	);

endmodule

/* hw/segment_voter.sv */
`timescale 1ns/1ps

module segment_voter #(
	parameter int SEG_INDEX = 0,
	parameter int MAX_PAYLOAD = 16
) (
	input  logic               rx_clk,
	input  logic               rst,
	payload_if.dst             pl,
	output rx_vote_pkg::byte_t vote_data,
	output logic               vote_en,
	output logic               loss
);
	import rx_vote_pkg::*;

	// Length counts saturate one past the buffer size to flag overlong copies.
	localparam int LEN_W = $clog2(MAX_PAYLOAD + 2);
	localparam int IDX_W = (MAX_PAYLOAD > 1) ? $clog2(MAX_PAYLOAD) : 1;
	localparam logic [LEN_W-1:0] LEN_MAX = LEN_W'(MAX_PAYLOAD);
	localparam logic [LEN_W-1:0] LEN_OVER = LEN_W'(MAX_PAYLOAD + 1);
	localparam seg_t MY_SEG = seg_t'(SEG_INDEX);

	byte_t            buf_a [MAX_PAYLOAD];
	byte_t            buf_b [MAX_PAYLOAD];
	copy_e            copy;
	logic [LEN_W-1:0] pos;
	logic [LEN_W-1:0] len_a;
	logic [LEN_W-1:0] len_b;
	logic [LEN_W-1:0] len_c;
	logic             check_pending;
	logic             mine;
	logic             take;
	logic             in_range;
	logic             last_copy;
	logic [IDX_W-1:0] idx;
	byte_t            a_byte;
	byte_t            b_byte;

	assign mine = pl.segment == MY_SEG;
	assign take = pl.valid && mine;
	assign in_range = pos < LEN_MAX;
	assign last_copy = copy == COPY_VOTE;
	assign idx = pos[IDX_W-1:0];
	assign a_byte = buf_a[idx];
	assign b_byte = buf_b[idx];

	always_ff @(posedge rx_clk) begin
		if (take && in_range) begin
			if (copy == COPY_A) begin
				buf_a[idx] <= pl.data;
			end
			if (copy == COPY_B) begin
				buf_b[idx] <= pl.data;
			end
		end
	end

	// Bitwise 2-of-3 majority.
	always_ff @(posedge rx_clk) begin
		if (take && last_copy) begin
			vote_data <= (a_byte & b_byte) | (a_byte & pl.data) | (b_byte & pl.data);
		end
	end

	always_ff @(posedge rx_clk) begin
		if (pl.frame_end && mine && last_copy) begin
			len_c <= pos;
		end
	end

	always_ff @(posedge rx_clk) begin
		if (rst) begin
			copy          <= COPY_A;
			pos           <= '0;
			len_a         <= '0;
			len_b         <= '0;
			check_pending <= 1'b0;
			vote_en       <= 1'b0;
			loss          <= 1'b0;
		end else begin
			vote_en       <= take && in_range && last_copy;
			check_pending <= 1'b0;
			// Lengths are compared the cycle after the third copy closes.
			loss <= check_pending &&
				((len_a != len_c) || (len_b != len_c) || (len_c == LEN_OVER));
			if (pl.frame_end && mine) begin
				pos <= '0;
				case (copy)
					COPY_A: begin
						len_a <= pos;
						copy  <= COPY_B;
					end
					COPY_B: begin
						len_b <= pos;
						copy  <= COPY_VOTE;
					end
					COPY_VOTE: begin
						check_pending <= 1'b1;
						copy          <= COPY_A;
					end
					default: copy <= COPY_A;
				endcase
			end else if (take && (pos != LEN_OVER)) begin
				pos <= pos + 1'b1;
			end
		end
	end

endmodule

/* hw/voter_bank.sv */
`timescale 1ns/1ps

module voter_bank #(
	parameter int SEGMENT_NUM_MAX = 4,
	parameter int MAX_PAYLOAD = 16
) (
	input  logic               rx_clk,
	input  logic               rst,
	payload_if.dst             pl,
	output logic               en_out,
	output rx_vote_pkg::byte_t data_out,
	output logic               loss_detected
);
	import rx_vote_pkg::*;

	byte_t                      seg_data [SEGMENT_NUM_MAX];
	logic [SEGMENT_NUM_MAX-1:0] seg_en;
	logic [SEGMENT_NUM_MAX-1:0] seg_loss;
	byte_t                      merged_data;

	generate
		for (genvar i = 0; i < SEGMENT_NUM_MAX; i++) begin : g_voter
			segment_voter #(
				.SEG_INDEX   (i),
				.MAX_PAYLOAD (MAX_PAYLOAD)
			) u_voter (
				.rx_clk    (rx_clk),
				.rst       (rst),
				.pl        (pl),
				.vote_data (seg_data[i]),
				.vote_en   (seg_en[i]),
				.loss      (seg_loss[i])
			);
		end
	endgenerate

	// At most one voter emits at a time, so an OR of gated bytes is enough.
	always_comb begin
		merged_data = '0;
		for (int i = 0; i < SEGMENT_NUM_MAX; i++) begin
			merged_data = merged_data | (seg_data[i] & {8{seg_en[i]}});
		end
	end

	always_ff @(posedge rx_clk) begin
		data_out <= merged_data;
	end

	always_ff @(posedge rx_clk) begin
		if (rst) begin
			en_out        <= 1'b0;
			loss_detected <= 1'b0;
		end else begin
			en_out        <= |seg_en;
			loss_detected <= |seg_loss;
		end
	end

endmodule

/* list.f */
hw/rx_vote_pkg.sv
hw/payload_if.sv
hw/frame_dispatcher.sv
hw/segment_voter.sv
hw/voter_bank.sv
hw/rx_vote_top.sv
tests/tb_clock.sv
tests/rx_vote_properties.sv
tests/rx_vote_tb.sv

/* tests/rx_vote_properties.sv */
`timescale 1ns/1ps

module rx_vote_properties (
	input logic rx_clk,
	input logic rst,
	input logic rx_enable,
	input logic en_out,
	input logic loss_detected,
	input logic bad_segment
);

	// One reset edge clears the output strobes.
	a_reset_quiet: assert property (@(posedge rx_clk) $past(rst) |-> !en_out && !loss_detected)
		else $error("en_out or loss_detected high after a reset cycle");

	a_bad_no_output: assert property (@(posedge rx_clk) disable iff (rst)
		!(bad_segment && en_out))
		else $error("bad_segment and en_out high in the same cycle");

	// A voted byte left the input three cycles earlier.
	a_en_out_latency: assert property (@(posedge rx_clk) disable iff (rst)
		en_out |-> $past(rx_enable, 3))
		else $error("en_out high without an enabled input byte three cycles before");

	a_loss_pulse: assert property (@(posedge rx_clk) disable iff (rst)
		loss_detected |=> !loss_detected)
		else $error("loss_detected longer than one cycle");

endmodule

bind rx_vote_top rx_vote_properties u_properties (
	.rx_clk        (rx_clk),
	.rst           (rst),
	.rx_enable     (rx_enable),
	.en_out        (en_out),
	.loss_detected (loss_detected),
	.bad_segment   (bad_segment)
);

/* tests/rx_vote_tb.sv */
`timescale 1ns/1ps

module rx_vote_tb;
	import rx_vote_pkg::*;

	localparam int SEGMENT_NUM_MAX = 4;
	localparam int SEG_OFFSET = 2;
	localparam int MAX_PAYLOAD = 16;
	// Payload starts right after the two segment bytes.
	localparam int PAYLOAD_START = SEG_OFFSET + 2;
	localparam int LATENCY = 3;
	localparam int LOSS_DELAY = 4;
	localparam int BAD_DELAY = 2;
	localparam int TIMEOUT = 60;
	localparam int SETTLE = 7;

	logic  rx_clk;
	logic  rst;
	byte_t rx_data;
	logic  rx_enable;
	logic  en_out;
	byte_t data_out;
	logic  loss_detected;
	logic  bad_segment;

	// Output log, filled by the monitor.
	int    cycle;
	int    out_cnt;
	byte_t out_data [256];
	int    out_at [256];
	int    loss_cnt;
	int    loss_at;
	int    bad_cnt;
	int    bad_at;

	// Frame under test and its expected results.
	byte_t frame [64];
	int    frame_len;
	int    in_at [64];
	byte_t expect_data [64];
	int    expect_cnt;
	logic  expect_loss;
	logic  expect_bad;

	int    fd;
	string test_name;
	int    errors;
	int    tests_run;
	int    tests_failed;

	tb_clock #(.PERIOD(8)) u_clock (.clk(rx_clk));

	rx_vote_top #(
		.SEGMENT_NUM_MAX (SEGMENT_NUM_MAX),
		.SEG_OFFSET      (SEG_OFFSET),
		.MAX_PAYLOAD     (MAX_PAYLOAD)
	) uut (
		.rx_clk        (rx_clk),
		.rst           (rst),
		.rx_data       (rx_data),
		.rx_enable     (rx_enable),
		.en_out        (en_out),
		.data_out      (data_out),
		.loss_detected (loss_detected),
		.bad_segment   (bad_segment)
	);

	// Each record carries the cycle in which the sampled value was present.
	always @(posedge rx_clk) begin
		cycle <= cycle + 1;
		if (!rst && en_out && out_cnt < 256) begin
			out_data[out_cnt] <= data_out;
			out_at[out_cnt]   <= cycle;
			out_cnt           <= out_cnt + 1;
		end
		if (!rst && loss_detected) begin
			loss_cnt <= loss_cnt + 1;
			loss_at  <= cycle;
		end
		if (!rst && bad_segment) begin
			bad_cnt <= bad_cnt + 1;
			bad_at  <= cycle;
		end
	end

	task automatic check_byte(input string what, input byte_t expected, input byte_t actual);
		if (actual !== expected) begin
			errors++;
			$display("mismatch %s %s: expected %h, actual %h", test_name, what, expected, actual);
		end
	endtask

	task automatic check_flag(input string what, input logic expected, input logic actual);
		if (actual !== expected) begin
			errors++;
			$display("mismatch %s %s: expected %b, actual %b", test_name, what, expected, actual);
		end
	endtask

	task automatic check_count(input string what, input int expected, input int actual);
		if (actual != expected) begin
			errors++;
			$display("mismatch %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
		end
	endtask

	function automatic bit read_value(input bit hex, output int value);
		int code;
		if (hex) begin
			code = $fscanf(fd, "%h", value);
		end else begin
			code = $fscanf(fd, "%d", value);
		end
		return code == 1;
	endfunction

	task automatic read_frame(output bit ok);
		int v;
		ok = read_value(1'b0, frame_len) && frame_len > 0 && frame_len <= 64;
		for (int i = 0; ok && i < frame_len; i++) begin
			ok = read_value(1'b1, v);
			frame[i] = byte_t'(v);
		end
		if (ok) begin
			ok = read_value(1'b0, expect_cnt) && expect_cnt >= 0 && expect_cnt <= 64;
		end
		for (int i = 0; ok && i < expect_cnt; i++) begin
			ok = read_value(1'b1, v);
			expect_data[i] = byte_t'(v);
		end
		if (ok) begin
			ok = read_value(1'b0, v);
			expect_loss = v[0];
		end
		if (ok) begin
			ok = read_value(1'b0, v);
			expect_bad = v[0];
		end
	endtask

	task automatic wait_cycle(inout int waited);
		@(posedge rx_clk);
		waited++;
	endtask

	task automatic run_frame();
		int out_base;
		int loss_base;
		int bad_base;
		int fall_at;
		int seg_at;
		int got;
		int waited;
		out_base  = out_cnt;
		loss_base = loss_cnt;
		bad_base  = bad_cnt;
		seg_at    = 0;
		for (int i = 0; i < frame_len; i++) begin
			@(posedge rx_clk);
			rx_enable <= 1'b1;
			rx_data   <= frame[i];
			if (i == SEG_OFFSET + 1) begin
				seg_at = cycle + 1;
			end
			if (i >= PAYLOAD_START) begin
				in_at[i - PAYLOAD_START] = cycle + 1;
			end
		end
		@(posedge rx_clk);
		rx_enable <= 1'b0;
		rx_data   <= '0;
		fall_at = cycle + 1;
		waited = 0;
		while (out_cnt - out_base < expect_cnt && waited < TIMEOUT) begin
			wait_cycle(waited);
		end
		if (out_cnt - out_base < expect_cnt) begin
			errors++;
			$display("%s: en_out did not deliver the expected bytes in time", test_name);
		end
		waited = 0;
		while (expect_loss && loss_cnt == loss_base && waited < TIMEOUT) begin
			wait_cycle(waited);
		end
		waited = 0;
		while (expect_bad && bad_cnt == bad_base && waited < TIMEOUT) begin
			wait_cycle(waited);
		end
		// Nothing more is due once the loss slot has passed.
		waited = 0;
		while (cycle < fall_at + SETTLE && waited < TIMEOUT) begin
			wait_cycle(waited);
		end
		got = out_cnt - out_base;
		check_count("output count", expect_cnt, got);
		for (int i = 0; i < expect_cnt && i < got; i++) begin
			check_byte($sformatf("byte %0d", i), expect_data[i], out_data[out_base + i]);
			check_count($sformatf("latency of byte %0d", i), LATENCY,
				out_at[out_base + i] - in_at[i]);
		end
		check_flag("loss_detected", expect_loss, loss_cnt != loss_base);
		check_flag("bad_segment", expect_bad, bad_cnt != bad_base);
		if (expect_loss && loss_cnt != loss_base) begin
			check_count("loss pulses", 1, loss_cnt - loss_base);
			check_count("loss delay", LOSS_DELAY, loss_at - fall_at);
		end
		if (expect_bad && bad_cnt != bad_base) begin
			check_count("bad_segment pulses", 1, bad_cnt - bad_base);
			check_count("bad_segment delay", BAD_DELAY, bad_at - seg_at);
		end
	endtask

	task automatic finish_test(input int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			$display("test %s: ok", test_name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", test_name, errors - errors_before);
		end
	endtask

	task automatic run_tests();
		logic [8*32-1:0]  tok;
		logic [8*160-1:0] rest;
		int               code;
		int               test_errors;
		bit               in_test;
		bit               done;
		bit               ok;
		in_test = 1'b0;
		done = 1'b0;
		test_errors = 0;
		while (!done) begin
			tok = '0;
			code = $fscanf(fd, "%s", tok);
			if (code != 1) begin
				done = 1'b1;
			end else if (tok == "#") begin
				code = $fgets(rest, fd);
			end else if (tok == "test") begin
				if (in_test) begin
					finish_test(test_errors);
				end
				tok = '0;
				code = $fscanf(fd, "%s", tok);
				test_name = $sformatf("%0s", tok);
				test_errors = errors;
				in_test = 1'b1;
			end else if (tok == "frame" && in_test) begin
				read_frame(ok);
				if (ok) begin
					run_frame();
				end else begin
					errors++;
					$display("%s: malformed frame line in the test file", test_name);
					done = 1'b1;
				end
			end else begin
				errors++;
				$display("unexpected word in the test file: %0s", tok);
				done = 1'b1;
			end
		end
		if (in_test) begin
			finish_test(test_errors);
		end
	endtask

	initial begin
		rst       = 1'b1;
		rx_enable = 1'b0;
		rx_data   = '0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		fd = $fopen("tests/rx_vote_tests.txt", "r");
		repeat (5) @(posedge rx_clk);
		rst <= 1'b0;
		if (fd == 0) begin
			errors++;
			$display("could not open tests/rx_vote_tests.txt");
		end else begin
			run_tests();
			$fclose(fd);
			if (tests_run == 0) begin
				errors++;
				$display("the test file holds no tests");
			end
		end
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

/* tests/rx_vote_tests.txt */
# Columns: frame, byte count, frame bytes in hex (header then payload),
# voted byte count, voted bytes in hex, loss flag, bad_segment flag.

# Three clean copies of segment 1.
test identical
frame 12 5a a5 00 01 11 22 33 44 55 66 77 88 0 0 0
frame 12 5a a5 00 01 11 22 33 44 55 66 77 88 0 0 0
frame 12 5a a5 00 01 11 22 33 44 55 66 77 88 8 11 22 33 44 55 66 77 88 0 0

# Segment 2, each copy damaged at its own positions.
test corrupted
frame 12 5a a5 00 02 df ad be ef f1 02 03 04 0 0 0
frame 12 5a a5 00 02 de ad be 6f 01 02 03 0c 0 0 0
frame 12 5a a5 00 02 de 2d be ef 01 02 83 04 8 de ad be ef 01 02 03 04 0 0

# Segments 0 and 3 interleaved as A0 A1 B0 A2 B1 B2.
test interleaved
frame 9 5a a5 00 00 10 20 30 40 50 0 0 0
frame 9 5a a5 00 00 10 20 30 40 50 0 0 0
frame 10 3c c3 00 03 c1 c2 c3 c4 c5 c6 0 0 0
frame 9 5a a5 00 00 10 24 30 40 50 5 10 20 30 40 50 0 0
frame 10 3c c3 00 03 c1 c2 c3 c4 c5 c6 0 0 0
frame 10 3c c3 00 03 c1 c2 c3 c4 d5 c6 6 c1 c2 c3 c4 c5 c6 0 0

# Third copy of segment 1 stops two bytes early.
test short_copy
frame 10 5a a5 00 01 01 23 45 67 89 ab 0 0 0
frame 10 5a a5 00 01 01 23 45 67 89 ab 0 0 0
frame 8 5a a5 00 01 01 23 45 67 4 01 23 45 67 1 0

# Segment numbers past the last voter.
test bad_segment
frame 7 5a a5 00 04 99 88 77 0 0 1
frame 6 5a a5 01 00 99 88 0 0 1

/* tests/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD = 8
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	// First rising edge comes half a period in.
	always begin
		#(PERIOD / 2) clk = ~clk;
	end

endmodule
